//--- Bender.yml
package:
  name: sdram_model

sources:
  - sdram_pkg.sv
  - sdram_cmd_decode.sv
  - sdram_burst_ctrl.sv
  - sdram_array.sv
  - sdram_dq_io.sv
  - sdram_model.sv
  - target: test
    files:
      - sdram_model_tb.sv

//--- sdram_array.sv
`timescale 1ns/10ps

module sdram_array #(
  parameter int row_w = 4,
  parameter int col_w = 6
) (
  input  logic                  clk,
  input  logic                  cke,
  input  sdram_pkg::array_req_s acc,
  output sdram_pkg::word_t      rd_data,
  output logic                  rd_valid
);

  import sdram_pkg::*;

  localparam int addr_w = 2 + row_w + col_w;
  localparam int depth  = 2 ** addr_w;

  word_t             mem [depth];
  logic [addr_w-1:0] idx;

  // upper row and column bits alias
  assign idx = {acc.bank, acc.row[row_w-1:0], acc.col[col_w-1:0]};

  always_ff @(posedge clk) begin
    if (acc.wr) begin
      if (!acc.mask[0]) begin
        mem[idx][7:0] <= acc.data[7:0];
      end
      if (!acc.mask[1]) begin
        mem[idx][15:8] <= acc.data[15:8];
      end
    end
    if (acc.rd) begin
      rd_data <= mem[idx];
    end
  end

  always_ff @(posedge clk or posedge cke) begin
    if (cke) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= acc.rd;
    end
  end

endmodule

//--- sdram_burst_ctrl.sv
`timescale 1ns/10ps

module sdram_burst_ctrl #(
  parameter int row_w = 4,
  parameter int col_w = 6
) (
  input  logic                  clk,
  input  logic                  cke,
  input  sdram_pkg::sdram_req_s req,
  input  sdram_pkg::mode_s      mode,
  output sdram_pkg::array_req_s acc
);

  import sdram_pkg::*;

  burst_state_e     state;
  beat_cnt_t        beat_cnt;
  beat_cnt_t        beat_len;
  beat_cnt_t        beat_next;
  beat_cnt_t        start_len;
  logic             start;
  logic             issue;
  logic             rd_q;
  logic             wr_q;
  bank_t            bank_q;
  logic [row_w-1:0] row_q;
  logic [col_w-1:0] col_q;
  word_t            data_q;
  mask_t            mask_q;

  assign start     = req.rd | req.wr;
  assign start_len = beat_cnt_t'(1) << mode.burst_len;
  assign beat_next = beat_cnt + beat_cnt_t'(1);

  // a new start wins over a running burst, terminate only stops it
  assign issue = start | ((state != st_idle) & ~req.term);

  always_ff @(posedge clk or posedge cke) begin
    if (cke) begin
      state    <= st_idle;
      beat_cnt <= '0;
      beat_len <= '0;
      rd_q     <= 1'b0;
      wr_q     <= 1'b0;
    end else if (start) begin
      beat_cnt <= beat_cnt_t'(1);
      beat_len <= start_len;
      rd_q     <= req.rd;
      wr_q     <= req.wr;
      if (start_len == beat_cnt_t'(1)) begin
        state <= st_idle;
      end else if (req.rd) begin
        state <= st_read;
      end else begin
        state <= st_write;
      end
    end else if (issue) begin
      beat_cnt <= beat_next;
      rd_q     <= (state == st_read);
      wr_q     <= (state == st_write);
      if (beat_next == beat_len) begin
        state <= st_idle;
      end
    end else begin
      state <= st_idle;
      rd_q  <= 1'b0;
      wr_q  <= 1'b0;
    end
  end

  // address held for the burst, column steps within col_w bits
  always_ff @(posedge clk) begin
    if (start) begin
      bank_q <= req.bank;
      row_q  <= req.row[row_w-1:0];
      col_q  <= req.col[col_w-1:0];
    end else if (issue) begin
      col_q <= col_q + 1'b1;
    end
    // write beat k uses the pins of its own cycle
    data_q <= req.data;
    mask_q <= req.mask;
  end

  always_comb begin
    acc      = '0;
    acc.rd   = rd_q;
    acc.wr   = wr_q;
    acc.bank = bank_q;
    acc.row  = row_t'(row_q);
    acc.col  = col_t'(col_q);
    acc.data = data_q;
    acc.mask = mask_q;
  end

endmodule

//--- sdram_cmd_decode.sv
`timescale 1ns/10ps

module sdram_cmd_decode (
  input  logic                 clk,
  input  logic                 cke,
  input  logic                 cs,
  input  logic                 ras,
  input  logic                 cas,
  input  logic                 we,
  input  sdram_pkg::row_t      a,
  input  sdram_pkg::bank_t     ba,
  input  sdram_pkg::mask_t     dqm,
  input  sdram_pkg::word_t     dq_in,
  output sdram_pkg::sdram_req_s req,
  output sdram_pkg::mode_s     mode
);

  import sdram_pkg::*;

  sdram_cmd_t cmd;
  row_t       open_row [4];

  // deselected device sees a nop
  assign cmd = cs ? cmd_nop : sdram_cmd_t'({ras, cas, we});

  // mode register, loaded from the address pins
  always_ff @(posedge clk or posedge cke) begin
    if (cke) begin
      mode.cas_lat   <= cas_lat_t'(2);
      mode.burst_len <= bl_2;
    end else if (cmd == cmd_load_mode) begin
      if (a[6:4] == 3'd3) begin
        mode.cas_lat <= cas_lat_t'(3);
      end else begin
        mode.cas_lat <= cas_lat_t'(2);
      end
      // codes 4 to 7 fall back to a single beat
      if (a[2]) begin
        mode.burst_len <= bl_1;
      end else begin
        mode.burst_len <= burst_len_e'(a[1:0]);
      end
    end
  end

  // one open row per bank
  always_ff @(posedge clk or posedge cke) begin
    if (cke) begin
      for (int i = 0; i < 4; i++) begin
        open_row[i] <= '0;
      end
    end else if (cmd == cmd_active) begin
      open_row[ba] <= a;
    end
  end

  always_comb begin
    req      = '0;
    req.bank = ba;
    req.row  = open_row[ba];
    req.col  = col_t'(a[8:0]);
    // data and mask pass every cycle for the later write beats
    req.data = dq_in;
    req.mask = dqm;
    case (cmd)
      cmd_read: begin
        req.rd = 1'b1;
      end
      cmd_write: begin
        req.wr = 1'b1;
      end
      cmd_terminate: begin
        req.term = 1'b1;
      end
      // no burst action; precharge and refresh are accepted and ignored
      cmd_nop, cmd_active, cmd_precharge, cmd_refresh, cmd_load_mode: begin
        req.term = 1'b0;
      end
      default: begin
        req.term = 1'b0;
      end
    endcase
  end

endmodule

//--- sdram_dq_io.sv
`timescale 1ns/10ps

module sdram_dq_io (
  input  logic                  clk,
  input  logic                  cke,
  input  sdram_pkg::word_t      rd_data,
  input  logic                  rd_valid,
  input  sdram_pkg::cas_lat_t   cas_lat,
  output sdram_pkg::word_t      dq_in,
  inout  wire sdram_pkg::word_t dq
);

  import sdram_pkg::*;

  word_t data_q;
  logic  valid_q;
  word_t out_data;
  logic  out_en;
  logic  use_delay;

  // extra stage for cl 3
  always_ff @(posedge clk or posedge cke) begin
    if (cke) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= rd_data;
  end

  assign use_delay = (cas_lat == cas_lat_t'(3));

  always_comb begin
    if (use_delay) begin
      out_en   = valid_q;
      out_data = data_q;
    end else begin
      out_en   = rd_valid;
      out_data = rd_data;
    end
  end

  // bus released whenever no read beat is due
  assign dq    = out_en ? out_data : 'z;
  assign dq_in = dq;

endmodule

//--- sdram_model.sv
`timescale 1ns/10ps

module sdram_model #(
  parameter int row_w = 4,
  parameter int col_w = 6
) (
  input  logic                  clk,
  input  logic                  cke,
  input  logic                  cs,
  input  logic                  ras,
  input  logic                  cas,
  input  logic                  we,
  input  sdram_pkg::row_t       a,
  input  sdram_pkg::bank_t      ba,
  input  sdram_pkg::mask_t      dqm,
  inout  wire sdram_pkg::word_t dq
);

  import sdram_pkg::*;

  sdram_req_s req;
  mode_s      mode;
  array_req_s acc;
  word_t      rd_data;
  logic       rd_valid;
  word_t      dq_in;

  sdram_cmd_decode u_decode (
    .clk   (clk),
    .cke   (cke),
    .cs    (cs),
    .ras   (ras),
    .cas   (cas),
    .we    (we),
    .a     (a),
    .ba    (ba),
    .dqm   (dqm),
    .dq_in (dq_in),
    .req   (req),
    .mode  (mode)
  );

  sdram_burst_ctrl #(
    .row_w (row_w),
    .col_w (col_w)
  ) u_burst (
    .clk  (clk),
    .cke  (cke),
    .req  (req),
    .mode (mode),
    .acc  (acc)
  );

  sdram_array #(
    .row_w (row_w),
    .col_w (col_w)
  ) u_array (
    .clk      (clk),
    .cke      (cke),
    .acc      (acc),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  sdram_dq_io u_dq_io (
    .clk      (clk),
    .cke      (cke),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .cas_lat  (mode.cas_lat),
    .dq_in    (dq_in),
    .dq       (dq)
  );

endmodule

//--- sdram_model_tb.sv
`timescale 1ns/10ps

module sdram_model_tb;

  import sdram_pkg::*;

  localparam int row_w      = 4;
  localparam int col_w      = 6;
  localparam int max_steps  = 256;
  localparam int rst_cycles = 4;

  // one table row per clock cycle
  typedef struct packed {
    logic       cs;
    sdram_cmd_t cmd;
    bank_t      ba;
    row_t       a;
    mask_t      dqm;
    word_t      wdata;
    logic       drv;
    word_t      exp_data;
    logic       exp_en;
    logic       exp_z;
  } step_s;

  logic       clk = 1'b0;
  logic       cke;
  logic       cs;
  logic       ras;
  logic       cas;
  logic       we;
  row_t       a;
  bank_t      ba;
  mask_t      dqm;
  word_t      dq_drv;
  logic       dq_oe;
  wire word_t dq;

  step_s tbl [max_steps];
  word_t img [4 * (2 ** (row_w + col_w))];
  row_t  open_row [4];
  int    cur;
  int    n_steps;
  int    cl;
  int    bl;
  int    seed   = 75165;
  int    cycles = 0;
  int    limit  = max_steps + 20;

  always #20 clk = ~clk;

  assign dq = dq_oe ? dq_drv : 'z;

  sdram_model #(
    .row_w (row_w),
    .col_w (col_w)
  ) UUT (
    .clk (clk),
    .cke (cke),
    .cs  (cs),
    .ras (ras),
    .cas (cas),
    .we  (we),
    .a   (a),
    .ba  (ba),
    .dqm (dqm),
    .dq  (dq)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, stimulus table not finished", limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      $display("sim failed");
      $fatal(1, "bus state mismatch");
    end
  endtask

  // storage index with the upper row and column bits aliased
  function automatic int img_addr(input bank_t b, input row_t r, input int c);
    col_t cc;
    cc = col_t'(c);
    return int'({b, r[row_w-1:0], cc[col_w-1:0]});
  endfunction

  task automatic store(input bank_t b, input int c, input word_t d, input mask_t m);
    int i;
    i = img_addr(b, open_row[b], c);
    if (!m[0]) begin
      img[i][7:0] = d[7:0];
    end
    if (!m[1]) begin
      img[i][15:8] = d[15:8];
    end
  endtask

  // appends one cycle and tracks mode and open rows as the device would
  task automatic put_entry(input logic sel_n, input sdram_cmd_t cmd, input bank_t b,
                           input row_t av, input mask_t m, input word_t d, input logic drv);
    tbl[cur].cs    = sel_n;
    tbl[cur].cmd   = cmd;
    tbl[cur].ba    = b;
    tbl[cur].a     = av;
    tbl[cur].dqm   = m;
    tbl[cur].wdata = d;
    tbl[cur].drv   = drv;
    cur++;
    if (!sel_n && cmd == cmd_active) begin
      open_row[b] = av;
    end
    if (!sel_n && cmd == cmd_load_mode) begin
      cl = (av[6:4] == 3'd3) ? 3 : 2;
      bl = av[2] ? 1 : (1 << av[1:0]);
    end
  endtask

  task automatic put_nop(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      put_entry(1'b0, cmd_nop, '0, '0, '0, '0, 1'b0);
    end
  endtask

  // a burst longer than n beats has to be cut by the next command
  task automatic write_beats(input bank_t b, input int c, input int n, input mask_t m);
    int    k;
    int    rnd;
    word_t d;
    for (k = 0; k < n; k++) begin
      rnd = $random(seed);
      d   = rnd[15:0];
      if (k == 0) begin
        put_entry(1'b0, cmd_write, b, row_t'(c), m, d, 1'b1);
      end else begin
        put_entry(1'b0, cmd_nop, b, '0, m, d, 1'b1);
      end
      store(b, c + k, d, m);
    end
  endtask

  task automatic expect_read(input int r, input bank_t b, input int c, input int n);
    int k;
    for (k = 0; k < n; k++) begin
      tbl[r + cl + k].exp_en   = 1'b1;
      tbl[r + cl + k].exp_data = img[img_addr(b, open_row[b], c + k)];
    end
  endtask

  task automatic expect_z(input int i);
    tbl[i].exp_z = 1'b1;
  endtask

  task automatic read_full(input bank_t b, input int c);
    int r;
    r = cur;
    put_entry(1'b0, cmd_read, b, row_t'(c), '0, '0, 1'b0);
    expect_z(r + cl - 1);
    expect_read(r, b, c, bl);
    expect_z(r + cl + bl);
    put_nop(cl + bl);
  endtask

  // terminate after n beats have been issued
  task automatic read_term(input bank_t b, input int c, input int n);
    int r;
    r = cur;
    put_entry(1'b0, cmd_read, b, row_t'(c), '0, '0, 1'b0);
    put_nop(n - 1);
    put_entry(1'b0, cmd_terminate, '0, '0, '0, '0, 1'b0);
    expect_read(r, b, c, n);
    expect_z(r + cl + n);
    expect_z(r + cl + n + 1);
    put_nop(cl + 2);
  endtask

  task automatic build_table();
    int    i;
    int    rnd;
    word_t d;
    for (i = 0; i < max_steps; i++) begin
      tbl[i]     = '0;
      tbl[i].cmd = cmd_nop;
    end
    for (i = 0; i < 4; i++) begin
      open_row[i] = '0;
    end
    cur = 0;
    cl  = 2;
    bl  = 2;
    // reset mode gives cl 2 and two beats
    expect_z(0);
    put_nop(1);
    put_entry(1'b0, cmd_active, 2'd0, 13'h0003, '0, '0, 1'b0);
    write_beats(2'd0, 4, 2, 2'b00);
    put_nop(1);
    read_full(2'd0, 4);
    // cl 3 with eight beats and the column wrapping past 63
    put_entry(1'b0, cmd_load_mode, '0, 13'h0033, '0, '0, 1'b0);
    write_beats(2'd0, 60, 8, 2'b00);
    put_nop(1);
    read_full(2'd0, 60);
    // cl field 1 and burst code 4 fall back to cl 2 and one beat
    put_entry(1'b0, cmd_load_mode, '0, 13'h0014, '0, '0, 1'b0);
    put_entry(1'b0, cmd_active, 2'd3, 13'h0002, '0, '0, 1'b0);
    write_beats(2'd3, 10, 1, 2'b00);
    write_beats(2'd3, 11, 1, 2'b00);
    write_beats(2'd3, 12, 1, 2'b00);
    write_beats(2'd3, 10, 1, 2'b01);
    write_beats(2'd3, 11, 1, 2'b10);
    write_beats(2'd3, 12, 1, 2'b11);
    put_nop(1);
    read_full(2'd3, 10);
    read_full(2'd3, 11);
    read_full(2'd3, 12);
    // two banks with the same column in different rows
    put_entry(1'b0, cmd_active, 2'd1, 13'h0005, '0, '0, 1'b0);
    put_entry(1'b0, cmd_active, 2'd2, 13'h0009, '0, '0, 1'b0);
    write_beats(2'd1, 7, 1, 2'b00);
    write_beats(2'd2, 7, 1, 2'b00);
    put_nop(1);
    for (i = 0; i < 4; i++) begin
      expect_read(cur, (i % 2 == 1) ? 2'd2 : 2'd1, 7, 1);
      put_entry(1'b0, cmd_read, (i % 2 == 1) ? 2'd2 : 2'd1, 13'd7, '0, '0, 1'b0);
    end
    expect_z(cur + cl);
    put_nop(cl + 1);
    // reopening a bank on another row keeps the first row intact
    put_entry(1'b0, cmd_active, 2'd1, 13'h0009, '0, '0, 1'b0);
    write_beats(2'd1, 7, 1, 2'b00);
    put_entry(1'b0, cmd_active, 2'd1, 13'h0005, '0, '0, 1'b0);
    read_full(2'd1, 7);
    // terminate and write restart
    put_entry(1'b0, cmd_load_mode, '0, 13'h0033, '0, '0, 1'b0);
    read_term(2'd0, 60, 2);
    write_beats(2'd1, 20, 3, 2'b00);
    write_beats(2'd1, 40, 8, 2'b00);
    put_nop(1);
    read_term(2'd1, 20, 3);
    read_full(2'd1, 40);
    // deselected commands, precharge and refresh leave everything alone
    rnd = $random(seed);
    d   = rnd[15:0];
    put_entry(1'b1, cmd_load_mode, '0, 13'h0000, '0, '0, 1'b0);
    put_entry(1'b1, cmd_active, 2'd0, 13'h0007, '0, '0, 1'b0);
    put_entry(1'b1, cmd_write, 2'd0, 13'd60, '0, d, 1'b1);
    put_entry(1'b0, cmd_precharge, 2'd0, 13'h0400, '0, '0, 1'b0);
    put_entry(1'b0, cmd_refresh, '0, '0, '0, '0, 1'b0);
    put_nop(1);
    read_full(2'd0, 60);
    read_full(2'd1, 40);
    put_nop(2);
  endtask

  task automatic apply_step(input step_s s);
    cs     = s.cs;
    ras    = s.cmd[2];
    cas    = s.cmd[1];
    we     = s.cmd[0];
    a      = s.a;
    ba     = s.ba;
    dqm    = s.dqm;
    dq_drv = s.wdata;
    dq_oe  = s.drv;
  endtask

  initial begin
    int i;
    cke    = 1'b1;
    cs     = 1'b1;
    ras    = 1'b1;
    cas    = 1'b1;
    we     = 1'b1;
    a      = '0;
    ba     = '0;
    dqm    = '0;
    dq_drv = '0;
    dq_oe  = 1'b0;
    build_table();
    n_steps = cur;
    limit   = rst_cycles + n_steps + 20;
    repeat (rst_cycles) @(posedge clk);
    #2;
    cke = 1'b0;
    for (i = 0; i < n_steps; i++) begin
      @(posedge clk);
      #2;
      apply_step(tbl[i]);
      // dq is settled mid-cycle before the edge that samples it
      @(negedge clk);
      if (tbl[i].exp_en) begin
        check_word("dq", tbl[i].exp_data, dq);
      end
      if (tbl[i].exp_z) begin
        check_flag("dq_hiz", 1'b1, dq === 16'hzzzz);
      end
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- sdram_pkg.sv
package sdram_pkg;

  // {ras, cas, we} as sampled on the pins
  typedef logic [2:0] sdram_cmd_t;

  localparam sdram_cmd_t cmd_nop       = 3'b111;
  localparam sdram_cmd_t cmd_active    = 3'b011;
  localparam sdram_cmd_t cmd_read      = 3'b101;
  localparam sdram_cmd_t cmd_write     = 3'b100;
  localparam sdram_cmd_t cmd_terminate = 3'b110;
  localparam sdram_cmd_t cmd_precharge = 3'b010;
  localparam sdram_cmd_t cmd_refresh   = 3'b001;
  localparam sdram_cmd_t cmd_load_mode = 3'b000;

  typedef logic [15:0] word_t;
  // bit 1 is the upper byte, set blocks the write
  typedef logic [1:0]  mask_t;
  typedef logic [1:0]  bank_t;
  typedef logic [12:0] row_t;
  typedef logic [8:0]  col_t;
  // holds 2 or 3 only
  typedef logic [1:0]  cas_lat_t;
  typedef logic [3:0]  beat_cnt_t;

  // encoding is log2 of the beat count
  typedef enum logic [1:0] {
    bl_1 = 2'd0,
    bl_2 = 2'd1,
    bl_4 = 2'd2,
    bl_8 = 2'd3
  } burst_len_e;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } burst_state_e;

  typedef struct packed {
    logic  rd;
    logic  wr;
    logic  term;
    bank_t bank;
    row_t  row;
    col_t  col;
    word_t data;
    mask_t mask;
  } sdram_req_s;

  typedef struct packed {
    logic  rd;
    logic  wr;
    bank_t bank;
    row_t  row;
    col_t  col;
    word_t data;
    mask_t mask;
  } array_req_s;

  typedef struct packed {
    cas_lat_t   cas_lat;
    burst_len_e burst_len;
  } mode_s;

endpackage

//--- tb.f
sdram_pkg.sv
sdram_cmd_decode.sv
sdram_burst_ctrl.sv
sdram_array.sv
sdram_dq_io.sv
sdram_model.sv
sdram_model_tb.sv
